// File: design/adder_pkg.sv
`default_nettype none

package adder_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Full operand width at the top
  localparam int DATA_W = 32;
  // One carry-select half
  localparam int LANE_W = DATA_W / 2;

  ////////////////////////////////////////////////////////////
  // Operation encoding and shared records
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } op_e;

  // Request as seen at the top-level input
  typedef struct packed {
    logic [DATA_W-1:0] op1;
    logic [DATA_W-1:0] op2;
    op_e               op;
  } add_req_t;

  // Operands after subtract conditioning
  typedef struct packed {
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic              cin;
  } prep_t;

  // Low lane, real carry-in
  typedef struct packed {
    logic [LANE_W-1:0] sum;
    logic              cout;
  } low_res_t;

  // High lane, both carry choices side by side
  typedef struct packed {
    logic [LANE_W-1:0] sum0;
    logic [LANE_W-1:0] sum1;
    logic              cout0;
    logic              cout1;
    logic              ovf0;
    logic              ovf1;
  } high_res_t;

  // Registered output of the unit
  typedef struct packed {
    logic [DATA_W-1:0] sum;
    logic              carry;
    logic              overflow;
    logic              zero;
    logic              negative;
  } add_res_t;

endpackage

`default_nettype wire

// File: design/bk_prefix_adder.sv
`timescale 1ns/1ns
`default_nettype none

module bk_prefix_adder #(
  parameter int WIDTH = adder_pkg::LANE_W
) (
  input  logic [WIDTH-1:0] op1,
  input  logic [WIDTH-1:0] op2,
  input  logic             cin,
  output logic [WIDTH-1:0] sum,
  output logic             cout
);

  // Tree depth
  localparam int LEVELS = $clog2(WIDTH);

  // Up-sweep levels, level 0 is the bitwise pair
  logic [LEVELS:0][WIDTH-1:0] up_g;
  logic [LEVELS:0][WIDTH-1:0] up_p;
  // Down-sweep levels, level 1 holds every prefix [0..i]
  logic [LEVELS:1][WIDTH-1:0] dn_g;
  logic [LEVELS:1][WIDTH-1:0] dn_p;
  // Carry into each bit, top entry is the carry out
  logic [WIDTH:0]             carry;

  ////////////////////////////////////////////////////////////
  // Bitwise generate and propagate
  ////////////////////////////////////////////////////////////

  assign up_g[0] = op1 & op2;
  // XOR propagate doubles as the half sum
  assign up_p[0] = op1 ^ op2;

  ////////////////////////////////////////////////////////////
  // Up-sweep
  ////////////////////////////////////////////////////////////

  // Node i at level l covers 2**l bits ending at i
  // Only nodes with (i+1) a multiple of the span get merged
  for (genvar l = 1; l <= LEVELS; l = l + 1) begin : g_up
    localparam int SPAN = 2 ** l;
    localparam int HALF = SPAN / 2;

    for (genvar i = 0; i < WIDTH; i = i + 1) begin : g_bit
      if ((i + 1) % SPAN == 0) begin : g_node
        // Upper group absorbs the lower neighbour
        assign up_g[l][i] = up_g[l-1][i] | (up_p[l-1][i] & up_g[l-1][i-HALF]);
        assign up_p[l][i] = up_p[l-1][i] & up_p[l-1][i-HALF];
      end else begin : g_pass
        assign up_g[l][i] = up_g[l-1][i];
        assign up_p[l][i] = up_p[l-1][i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Down-sweep
  ////////////////////////////////////////////////////////////

  // Top level already holds the full-width group at WIDTH-1
  assign dn_g[LEVELS] = up_g[LEVELS];
  assign dn_p[LEVELS] = up_p[LEVELS];

  // Each level fills the midpoints between finished prefixes
  // Node i-HALF is always complete one level up
  for (genvar d = LEVELS - 1; d >= 1; d = d - 1) begin : g_down
    localparam int SPAN = 2 ** d;
    localparam int HALF = SPAN / 2;

    for (genvar i = 0; i < WIDTH; i = i + 1) begin : g_bit
      if (((i + 1) % SPAN == HALF) && (i + 1 > SPAN)) begin : g_node
        assign dn_g[d][i] = dn_g[d+1][i] | (dn_p[d+1][i] & dn_g[d+1][i-HALF]);
        assign dn_p[d][i] = dn_p[d+1][i] & dn_p[d+1][i-HALF];
      end else begin : g_pass
        assign dn_g[d][i] = dn_g[d+1][i];
        assign dn_p[d][i] = dn_p[d+1][i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Carries and sum
  ////////////////////////////////////////////////////////////

  // Bit 0 sees the external carry directly
  assign carry[0] = cin;
  // Every other carry is a prefix group folded with cin
  assign carry[WIDTH:1] = dn_g[1] | (dn_p[1] & {WIDTH{cin}});

  assign sum  = up_p[0] ^ carry[WIDTH-1:0];
  // Carry out of the whole group
  assign cout = carry[WIDTH];

endmodule

`default_nettype wire

// File: design/request_stage.sv
`timescale 1ns/1ns
`default_nettype none

module request_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  adder_pkg::add_req_t in_req,
  output logic                prep_valid,
  output adder_pkg::prep_t    prep
);

  import adder_pkg::*;

  // Subtract request flag
  logic              is_sub;
  // Second operand after conditioning
  logic [DATA_W-1:0] b_next;

  ////////////////////////////////////////////////////////////
  // Operand conditioning
  ////////////////////////////////////////////////////////////

  assign is_sub = (in_req.op == OP_SUB);

  // a - b computed as a + ~b + 1
  assign b_next = in_req.op2 ^ {DATA_W{is_sub}};

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  // Valid strobe, one cycle behind the input
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prep_valid <= 1'b0;
    end else begin
      prep_valid <= in_valid;
    end
  end

  // Payload, held between strobes
  always_ff @(posedge clk) begin
    if (in_valid) begin
      prep.a   <= in_req.op1;
      prep.b   <= b_next;
      // The +1 of the two's complement
      prep.cin <= is_sub;
    end
  end

endmodule

`default_nettype wire

// File: design/high_select_lane.sv
`timescale 1ns/1ns
`default_nettype none

module high_select_lane (
  input  logic [adder_pkg::LANE_W-1:0] a_hi,
  input  logic [adder_pkg::LANE_W-1:0] b_hi,
  output adder_pkg::high_res_t         res
);

  import adder_pkg::*;

  // Sums and carries for each assumed carry-in
  logic [LANE_W-1:0] sum_c0;
  logic [LANE_W-1:0] sum_c1;
  logic              cout_c0;
  logic              cout_c1;

  // Signed overflow from sign bits only
  function automatic logic signed_ovf(input logic a_msb, input logic b_msb, input logic s_msb);
    return (a_msb == b_msb) && (s_msb != a_msb);
  endfunction

  // Assumes no carry from the low lane
  bk_prefix_adder #(
    .WIDTH (LANE_W)
  ) u_add_c0 (
    .op1  (a_hi),
    .op2  (b_hi),
    .cin  (1'b0),
    .sum  (sum_c0),
    .cout (cout_c0)
  );

  // Assumes a carry from the low lane
  bk_prefix_adder #(
    .WIDTH (LANE_W)
  ) u_add_c1 (
    .op1  (a_hi),
    .op2  (b_hi),
    .cin  (1'b1),
    .sum  (sum_c1),
    .cout (cout_c1)
  );

  assign res.sum0  = sum_c0;
  assign res.sum1  = sum_c1;
  assign res.cout0 = cout_c0;
  assign res.cout1 = cout_c1;
  // Top bit of the lane is bit 31 of the word
  assign res.ovf0  = signed_ovf(a_hi[LANE_W-1], b_hi[LANE_W-1], sum_c0[LANE_W-1]);
  assign res.ovf1  = signed_ovf(a_hi[LANE_W-1], b_hi[LANE_W-1], sum_c1[LANE_W-1]);

endmodule

`default_nettype wire

// File: design/result_combiner.sv
`timescale 1ns/1ns
`default_nettype none

module result_combiner (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 prep_valid,
  input  adder_pkg::low_res_t  low,
  input  adder_pkg::high_res_t high,
  output logic                 out_valid,
  output adder_pkg::add_res_t  out_res
);

  import adder_pkg::*;

  // Selected upper half
  logic [LANE_W-1:0] sum_hi;
  // Joined 32-bit sum
  logic [DATA_W-1:0] sum_full;
  // Next value of the output register
  add_res_t          res_d;

  ////////////////////////////////////////////////////////////
  // Carry-select join
  ////////////////////////////////////////////////////////////

  // Low carry-out picks the matching high precompute
  assign sum_hi   = low.cout ? high.sum1 : high.sum0;
  assign sum_full = {sum_hi, low.sum};

  always_comb begin
    res_d.sum      = sum_full;
    // Carry out of bit 31
    res_d.carry    = low.cout ? high.cout1 : high.cout0;
    res_d.overflow = low.cout ? high.ovf1 : high.ovf0;
    // Flags off the joined sum
    res_d.zero     = (sum_full == '0);
    res_d.negative = sum_full[DATA_W-1];
  end

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  // Single-cycle result strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= prep_valid;
    end
  end

  // Result held until the next valid
  always_ff @(posedge clk) begin
    if (prep_valid) begin
      out_res <= res_d;
    end
  end

endmodule

`default_nettype wire

// File: design/alu_adder_top.sv
`timescale 1ns/1ns
`default_nettype none

module alu_adder_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  adder_pkg::add_req_t in_req,
  output logic                out_valid,
  output adder_pkg::add_res_t out_res
);

  import adder_pkg::*;

  // Stage 1 outputs
  logic      prep_valid;
  prep_t     prep;
  // Lane results, both combinational
  wire low_res_t low_res;
  high_res_t high_res;

  ////////////////////////////////////////////////////////////
  // Request register
  ////////////////////////////////////////////////////////////

  request_stage u_request_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_req     (in_req),
    .prep_valid (prep_valid),
    .prep       (prep)
  );

  ////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////

  // Low half, real carry-in
  bk_prefix_adder #(
    .WIDTH (LANE_W)
  ) u_low_lane (
    .op1  (prep.a[LANE_W-1:0]),
    .op2  (prep.b[LANE_W-1:0]),
    .cin  (prep.cin),
    .sum  (low_res.sum),
    .cout (low_res.cout)
  );

  // High half, both carry choices
  high_select_lane u_high_lane (
    .a_hi (prep.a[DATA_W-1:LANE_W]),
    .b_hi (prep.b[DATA_W-1:LANE_W]),
    .res  (high_res)
  );

  ////////////////////////////////////////////////////////////
  // Join and output register
  ////////////////////////////////////////////////////////////

  result_combiner u_result_combiner (
    .clk        (clk),
    .rst_n      (rst_n),
    .prep_valid (prep_valid),
    .low        (low_res),
    .high       (high_res),
    .out_valid  (out_valid),
    .out_res    (out_res)
  );

endmodule

`default_nettype wire

// File: verification/tb_alu_adder.sv
`timescale 1ns/1ns
`default_nettype none

module tb_alu_adder;

  import adder_pkg::*;

  // Request counts per test
  localparam int NUM_ADD    = 2000;
  localparam int NUM_SUB    = 1000;
  localparam int NUM_CORNER = 5 * 5 * 2;
  localparam int NUM_BURST  = 300;
  localparam int TOTAL_REQ  = NUM_ADD + NUM_SUB + NUM_CORNER + NUM_BURST;

  logic     clk;
  logic     rst_n;
  logic     in_valid;
  add_req_t in_req;
  logic     out_valid;
  add_res_t out_res;

  // Model results waiting for the DUT with due cycle and test name
  add_res_t    exp_q[$];
  int          due_q[$];
  string       name_q[$];
  logic [31:0] rng_state;
  logic [31:0] corner_val [0:4];
  int          cycle;
  int          errors;
  int          checked;
  int          issued;
  int          low_carry_seen;

  alu_adder_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_res   (out_res)
  );

  ////////////////////////////////////////////////////////////
  // Clock and cycle count
  ////////////////////////////////////////////////////////////

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  ////////////////////////////////////////////////////////////
  // Random source and model
  ////////////////////////////////////////////////////////////

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_rand(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  // Reference result from 33-bit unsigned and 64-bit signed arithmetic
  function automatic add_res_t model_result(input add_req_t req);
    logic [DATA_W:0] wide;
    longint          s_full;
    add_res_t        r;
    if (req.op == OP_ADD) begin
      wide   = {1'b0, req.op1} + {1'b0, req.op2};
      s_full = longint'($signed(req.op1)) + longint'($signed(req.op2));
      r.carry = wide[DATA_W];
    end else begin
      wide   = {1'b0, req.op1} - {1'b0, req.op2};
      s_full = longint'($signed(req.op1)) - longint'($signed(req.op2));
      // No borrow when op1 is at least op2
      r.carry = (req.op1 >= req.op2);
    end
    r.sum      = wide[DATA_W-1:0];
    r.overflow = (s_full > 64'sh7FFFFFFF) || (s_full < -64'sh80000000);
    r.zero     = (r.sum == '0);
    r.negative = r.sum[DATA_W-1];
    return r;
  endfunction

  // Carry from the low half of an add to see the select path used
  function automatic logic low_half_carry(input add_req_t req);
    logic [LANE_W:0] w;
    w = {1'b0, req.op1[LANE_W-1:0]} + {1'b0, req.op2[LANE_W-1:0]};
    return w[LANE_W];
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////

  // One strobe held for a single cycle
  task automatic issue(input logic [31:0] op1, input logic [31:0] op2, input op_e op,
                       input string name);
    add_req_t req;
    req.op1 = op1;
    req.op2 = op2;
    req.op  = op;
    if (op == OP_ADD && low_half_carry(req)) low_carry_seen++;
    in_valid = 1'b1;
    in_req   = req;
    exp_q.push_back(model_result(req));
    due_q.push_back(cycle + 2);
    name_q.push_back(name);
    issued++;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic idle();
    in_valid = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic report_value(input string name, input string field,
                              input logic [31:0] exp_v, input logic [31:0] act_v);
    errors++;
    $display("FAILED %s %s: expected %h, actual %h", name, field, exp_v, act_v);
  endtask

  ////////////////////////////////////////////////////////////
  // Output checker
  ////////////////////////////////////////////////////////////

  // Sampled mid-cycle away from the clock edge
  always @(negedge clk) begin : check_outputs
    add_res_t exp_res;
    string    name;
    int       due;
    // Registers stay unknown until the first clock edge
    if (cycle > 0) begin
      if (!rst_n) begin
        if (out_valid !== 1'b0) begin
          errors++;
          $display("ERROR: out_valid not low during reset at cycle %0d", cycle);
        end
      end else if (out_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERROR: out_valid high at cycle %0d with no request in flight", cycle);
        end else begin
          exp_res = exp_q.pop_front();
          due     = due_q.pop_front();
          name    = name_q.pop_front();
          checked++;
          if (due != cycle) begin
            errors++;
            $display("ERROR: %s result at cycle %0d, due at cycle %0d", name, cycle, due);
          end
          if (out_res.sum !== exp_res.sum)
            report_value(name, "sum", exp_res.sum, out_res.sum);
          if (out_res.carry !== exp_res.carry)
            report_value(name, "carry", exp_res.carry, out_res.carry);
          if (out_res.overflow !== exp_res.overflow)
            report_value(name, "overflow", exp_res.overflow, out_res.overflow);
          if (out_res.zero !== exp_res.zero)
            report_value(name, "zero", exp_res.zero, out_res.zero);
          if (out_res.negative !== exp_res.negative)
            report_value(name, "negative", exp_res.negative, out_res.negative);
        end
      end else if (out_valid !== 1'b0) begin
        errors++;
        $display("ERROR: out_valid unknown at cycle %0d", cycle);
      end else if (exp_q.size() != 0 && due_q[0] <= cycle) begin
        // Skipped result dropped so later ones still line up
        errors++;
        $display("ERROR: %s result missing at cycle %0d", name_q[0], cycle);
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
        void'(name_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    repeat ((TOTAL_REQ + 20) * 3) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, %0d of %0d results checked",
             cycle, checked, TOTAL_REQ);
    $display("Regression failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main_seq
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    int          n;
    int          len;
    clk            = 1'b0;
    rst_n          = 1'b0;
    in_valid       = 1'b0;
    in_req         = '0;
    cycle          = 0;
    errors         = 0;
    checked        = 0;
    issued         = 0;
    low_carry_seen = 0;
    rng_state      = 32'd4471;
    corner_val[0]  = 32'h0000_0000;
    corner_val[1]  = 32'hFFFF_FFFF;
    corner_val[2]  = 32'h7FFF_FFFF;
    corner_val[3]  = 32'h8000_0000;
    corner_val[4]  = 32'h0000_0001;

    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Quiet stretch where out_valid must stay low
    repeat (6) idle();

    // Random adds with a strobe on about three cycles in four
    n = 0;
    while (n < NUM_ADD) begin
      next_rand(r);
      if (r[1:0] != 2'b00) begin
        next_rand(a);
        next_rand(b);
        issue(a, b, OP_ADD, "random_add");
        n++;
      end else begin
        idle();
      end
    end
    if (low_carry_seen == 0) begin
      errors++;
      $display("ERROR: no add carried from the low half into the high half");
    end

    // Random subtracts with some equal operands
    for (int i = 0; i < NUM_SUB; i++) begin
      next_rand(a);
      next_rand(r);
      b = (r[3:0] == 4'h0) ? a : r;
      issue(a, b, OP_SUB, "random_sub");
    end

    // Corner pairs for both operations
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        issue(corner_val[i], corner_val[j], OP_ADD, "corner");
        issue(corner_val[i], corner_val[j], OP_SUB, "corner");
      end
    end

    // Bursts of up to 8 with short gaps
    n = 0;
    while (n < NUM_BURST) begin
      next_rand(r);
      len = r[2:0] + 1;
      for (int k = 0; k < len && n < NUM_BURST; k++) begin
        next_rand(a);
        next_rand(b);
        issue(a, b, op_e'(a[0] ^ b[0]), "burst");
        n++;
      end
      repeat (r[4:3]) idle();
    end

    // Drain and then watch for stray strobes
    while (exp_q.size() != 0) idle();
    repeat (8) idle();

    $display("Summary: %0d issued, %0d checked, %0d errors", issued, checked, errors);
    if (errors == 0 && checked == TOTAL_REQ) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
design/adder_pkg.sv
design/bk_prefix_adder.sv
design/request_stage.sv
design/high_select_lane.sv
design/result_combiner.sv
design/alu_adder_top.sv
verification/tb_alu_adder.sv

// File: Bender.yml
package:
  name: alu_adder

sources:
  - files:
      - design/adder_pkg.sv
      - design/bk_prefix_adder.sv
      - design/request_stage.sv
      - design/high_select_lane.sv
      - design/result_combiner.sv
      - design/alu_adder_top.sv
  - target: simulation
    files:
      - verification/tb_alu_adder.sv
